// File: src/isa_pkg.sv
//****************************
// instruction set of the MIPS subset
// field layout, opcodes and ALU codes
//****************************
package isa_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;
    localparam int IMM_WIDTH  = 16;

    // field positions inside the instruction word
    localparam int OP_LSB = 26;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [5:0]            opcode_t;
    typedef logic [5:0]            funct_t;
    typedef logic [2:0]            alu_op_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_ADDI  = 6'h08;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2b;

    localparam funct_t FN_ADD = 6'h20;
    localparam funct_t FN_SUB = 6'h22;
    localparam funct_t FN_AND = 6'h24;
    localparam funct_t FN_OR  = 6'h25;
    localparam funct_t FN_SLT = 6'h2a;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_SLT = 3'd4;

endpackage

// File: src/pipe_pkg.sv
//****************************
// pipeline sizing, queue and data memory
//****************************
package pipe_pkg;

    localparam int FETCH_DEPTH = 4;   // also the sender's starting credit
    localparam int DMEM_DEPTH  = 64;

    // word index is taken from ALU result bits 7..2
    localparam int WORD_LSB = 2;

    localparam int FETCH_PTR_W = $clog2(FETCH_DEPTH);
    localparam int DMEM_ADDR_W = $clog2(DMEM_DEPTH);

    typedef logic [FETCH_PTR_W-1:0] fetch_ptr_t;
    typedef logic [FETCH_PTR_W:0]   fetch_count_t;   // holds 0..FETCH_DEPTH
    typedef logic [DMEM_ADDR_W-1:0] dmem_addr_t;

endpackage

// File: src/pipe_if.sv
//****************************
// stage to stage bundles of the pipeline
//****************************
interface issue_if;
    logic           valid;
    isa_pkg::word_t instr;
    logic           take;

    modport source (output valid, output instr, input take);
    modport sink   (input valid, input instr, output take);
endinterface

interface ex_if;
    logic               valid;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    isa_pkg::alu_op_t   alu_op;
    logic               use_imm;
    isa_pkg::reg_addr_t dest;
    isa_pkg::word_t     op_a;
    isa_pkg::word_t     op_b;
    isa_pkg::word_t     imm;
    logic               pend_write;   // execute register still owes a write
    isa_pkg::reg_addr_t pend_dest;

    modport source (output valid, reg_write, mem_read, mem_write, alu_op, use_imm,
                    output dest, op_a, op_b, imm, input pend_write, pend_dest);
    modport sink   (input valid, reg_write, mem_read, mem_write, alu_op, use_imm,
                    input dest, op_a, op_b, imm, output pend_write, pend_dest);
endinterface

interface mem_if;
    logic               valid;
    logic               reg_write;
    logic               mem_read;
    logic               mem_write;
    isa_pkg::reg_addr_t dest;
    isa_pkg::word_t     alu_result;
    isa_pkg::word_t     store_data;
    logic               pend_write;   // memory register still owes a write
    isa_pkg::reg_addr_t pend_dest;

    modport source (output valid, reg_write, mem_read, mem_write, dest, alu_result,
                    output store_data);
    modport sink   (input valid, reg_write, mem_read, mem_write, dest, alu_result,
                    input store_data, output pend_write, pend_dest);
    modport hazard (input pend_write, pend_dest);
endinterface

interface wb_if;
    logic               valid;   // only for writes to a nonzero register
    isa_pkg::reg_addr_t dest;
    isa_pkg::word_t     data;

    modport source (output valid, dest, data);
    modport sink   (input valid, dest, data);
endinterface

// File: src/fetch_queue.sv
//****************************
// instruction queue in front of decode
// one credit goes back per instruction taken
//****************************
module fetch_queue (
    input  logic           SYS_clk,
    input  logic           SYS_reset,
    input  logic           instr_valid,
    input  isa_pkg::word_t instr,
    output logic           credit,
    issue_if.source        issue
);
    isa_pkg::word_t         buffer [pipe_pkg::FETCH_DEPTH];
    pipe_pkg::fetch_ptr_t   wr_ptr;
    pipe_pkg::fetch_ptr_t   rd_ptr;
    pipe_pkg::fetch_count_t count;
    logic                   pop;

    assign issue.valid = (count != '0);
    assign issue.instr = buffer[rd_ptr];
    assign pop         = issue.valid && issue.take;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            credit <= 1'b0;
        end
        else
        begin
            if (instr_valid)
                wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, wraps itself
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count  <= count + pipe_pkg::fetch_count_t'(instr_valid)
                            - pipe_pkg::fetch_count_t'(pop);
            credit <= pop;   // one cycle after the take
        end
    end

    // entry storage, written on every push
    always_ff @(posedge SYS_clk)
    begin
        if (instr_valid)
            buffer[wr_ptr] <= instr;
    end

endmodule

// File: src/reg_file.sv
//****************************
// register file, 32 x 32
// write-through, r0 reads zero
//****************************
module reg_file (
    input  logic               SYS_clk,
    input  isa_pkg::reg_addr_t rs_addr,
    input  isa_pkg::reg_addr_t rt_addr,
    output isa_pkg::word_t     rs_data,
    output isa_pkg::word_t     rt_data,
    wb_if.sink                 wb
);
    isa_pkg::word_t regs [isa_pkg::REG_COUNT];

    always_ff @(posedge SYS_clk)
    begin
        if (wb.valid)
            regs[wb.dest] <= wb.data;   // wb.valid never targets r0
    end

    // a read of the register written this cycle sees the new value
    always_comb
    begin
        if (rs_addr == '0)
            rs_data = '0;
        else if (wb.valid && (wb.dest == rs_addr))
            rs_data = wb.data;
        else
            rs_data = regs[rs_addr];

        if (rt_addr == '0)
            rt_data = '0;
        else if (wb.valid && (wb.dest == rt_addr))
            rt_data = wb.data;
        else
            rt_data = regs[rt_addr];
    end

endmodule

// File: src/decode_stage.sv
//****************************
// decode stage, control decode, register read
// and the interlock against execute and memory
//****************************
module decode_stage (
    input  logic   SYS_clk,
    input  logic   SYS_reset,
    issue_if.sink  issue,
    ex_if.source   ex_out,
    mem_if.hazard  mem_peek,
    wb_if.sink     wb
);
    logic               d_valid;
    isa_pkg::word_t     d_instr;
    isa_pkg::opcode_t   opcode;
    isa_pkg::funct_t    funct;
    isa_pkg::reg_addr_t rs;
    isa_pkg::reg_addr_t rt;
    isa_pkg::reg_addr_t rd;
    logic               reads_rt;
    logic               rs_busy;
    logic               rt_busy;
    logic               stall;

    // older instruction still has to write the register we read
    function automatic logic conflicts(input logic               pend_write,
                                       input isa_pkg::reg_addr_t pend_dest,
                                       input isa_pkg::reg_addr_t src);
        return pend_write && (pend_dest == src) && (src != '0);
    endfunction

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            d_valid <= 1'b0;
        else if (issue.take)
            d_valid <= issue.valid;   // empty queue leaves a bubble
    end

    always_ff @(posedge SYS_clk)
    begin
        if (issue.take)
            d_instr <= issue.instr;
    end

    assign opcode = isa_pkg::opcode_t'(d_instr >> isa_pkg::OP_LSB);
    assign funct  = isa_pkg::funct_t'(d_instr);
    assign rs     = isa_pkg::reg_addr_t'(d_instr >> isa_pkg::RS_LSB);
    assign rt     = isa_pkg::reg_addr_t'(d_instr >> isa_pkg::RT_LSB);
    assign rd     = isa_pkg::reg_addr_t'(d_instr >> isa_pkg::RD_LSB);

    always_comb
    begin
        ex_out.reg_write = 1'b0;
        ex_out.mem_read  = 1'b0;
        ex_out.mem_write = 1'b0;
        ex_out.alu_op    = isa_pkg::ALU_ADD;
        ex_out.use_imm   = 1'b0;
        ex_out.dest      = rt;
        reads_rt         = 1'b0;
        case (opcode)
            isa_pkg::OP_RTYPE:
            begin
                ex_out.dest = rd;
                reads_rt    = 1'b1;
                ex_out.reg_write = 1'b1;
                case (funct)
                    isa_pkg::FN_ADD: ex_out.alu_op = isa_pkg::ALU_ADD;
                    isa_pkg::FN_SUB: ex_out.alu_op = isa_pkg::ALU_SUB;
                    isa_pkg::FN_AND: ex_out.alu_op = isa_pkg::ALU_AND;
                    isa_pkg::FN_OR:  ex_out.alu_op = isa_pkg::ALU_OR;
                    isa_pkg::FN_SLT: ex_out.alu_op = isa_pkg::ALU_SLT;
                    default:         ex_out.reg_write = 1'b0;   // unknown funct, no-op
                endcase
            end
            isa_pkg::OP_ADDI:
            begin
                ex_out.reg_write = 1'b1;
                ex_out.use_imm   = 1'b1;
            end
            isa_pkg::OP_LW:
            begin
                ex_out.reg_write = 1'b1;
                ex_out.mem_read  = 1'b1;
                ex_out.use_imm   = 1'b1;
            end
            isa_pkg::OP_SW:
            begin
                ex_out.mem_write = 1'b1;
                ex_out.use_imm   = 1'b1;
                reads_rt         = 1'b1;   // store data
            end
            default: ;   // unknown opcode passes as a no-op
        endcase
    end

    assign rs_busy = conflicts(ex_out.pend_write, ex_out.pend_dest, rs)
                   || conflicts(mem_peek.pend_write, mem_peek.pend_dest, rs);
    assign rt_busy = reads_rt
                   && (conflicts(ex_out.pend_write, ex_out.pend_dest, rt)
                   ||  conflicts(mem_peek.pend_write, mem_peek.pend_dest, rt));
    assign stall   = d_valid && (rs_busy || rt_busy);

    assign issue.take   = !stall;
    assign ex_out.valid = d_valid && !stall;   // bubble while stalled
    assign ex_out.imm   = {{(isa_pkg::WORD_W - isa_pkg::IMM_WIDTH){d_instr[isa_pkg::IMM_WIDTH-1]}},
                           d_instr[isa_pkg::IMM_WIDTH-1:0]};

    reg_file u_reg_file (
        .SYS_clk (SYS_clk),
        .rs_addr (rs),
        .rt_addr (rt),
        .rs_data (ex_out.op_a),
        .rt_data (ex_out.op_b),
        .wb      (wb)
    );

endmodule

// File: src/execute_stage.sv
//****************************
// execute stage, operand select and ALU
//****************************
module execute_stage (
    input  logic  SYS_clk,
    input  logic  SYS_reset,
    ex_if.sink    ex_in,
    mem_if.source mem_out
);
    logic               e_valid;
    logic               e_reg_write;
    logic               e_mem_read;
    logic               e_mem_write;
    isa_pkg::alu_op_t   e_alu_op;
    logic               e_use_imm;
    isa_pkg::reg_addr_t e_dest;
    isa_pkg::word_t     e_op_a;
    isa_pkg::word_t     e_op_b;
    isa_pkg::word_t     e_imm;
    isa_pkg::word_t     alu_b;
    isa_pkg::word_t     alu_result;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            e_valid <= 1'b0;
        else
            e_valid <= ex_in.valid;
    end

    always_ff @(posedge SYS_clk)
    begin
        e_reg_write <= ex_in.reg_write;
        e_mem_read  <= ex_in.mem_read;
        e_mem_write <= ex_in.mem_write;
        e_alu_op    <= ex_in.alu_op;
        e_use_imm   <= ex_in.use_imm;
        e_dest      <= ex_in.dest;
        e_op_a      <= ex_in.op_a;
        e_op_b      <= ex_in.op_b;
        e_imm       <= ex_in.imm;
    end

    assign alu_b = e_use_imm ? e_imm : e_op_b;   // imm for addi, lw, sw

    always_comb
    begin
        case (e_alu_op)
            isa_pkg::ALU_SUB: alu_result = e_op_a - alu_b;
            isa_pkg::ALU_AND: alu_result = e_op_a & alu_b;
            isa_pkg::ALU_OR:  alu_result = e_op_a | alu_b;
            isa_pkg::ALU_SLT: alu_result = isa_pkg::word_t'($signed(e_op_a) < $signed(alu_b));
            default:          alu_result = e_op_a + alu_b;
        endcase
    end

    assign mem_out.valid      = e_valid;
    assign mem_out.reg_write  = e_reg_write;
    assign mem_out.mem_read   = e_mem_read;
    assign mem_out.mem_write  = e_mem_write;
    assign mem_out.dest       = e_dest;
    assign mem_out.alu_result = alu_result;
    assign mem_out.store_data = e_op_b;

    assign ex_in.pend_write = e_valid && e_reg_write;   // seen by the interlock
    assign ex_in.pend_dest  = e_dest;

endmodule

// File: src/memory_stage.sv
//****************************
// memory stage, data memory and writeback register
//****************************
module memory_stage (
    input  logic SYS_clk,
    input  logic SYS_reset,
    mem_if.sink  mem_in,
    wb_if.source wb_out
);
    isa_pkg::word_t       dmem [pipe_pkg::DMEM_DEPTH];
    logic                 m_valid;
    logic                 m_reg_write;
    logic                 m_mem_read;
    logic                 m_mem_write;
    isa_pkg::reg_addr_t   m_dest;
    isa_pkg::word_t       m_alu;
    isa_pkg::word_t       m_store;
    pipe_pkg::dmem_addr_t word_addr;
    isa_pkg::word_t       load_data;

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
        begin
            m_valid      <= 1'b0;
            wb_out.valid <= 1'b0;
        end
        else
        begin
            m_valid      <= mem_in.valid;
            wb_out.valid <= m_valid && m_reg_write && (m_dest != '0);   // r0 writes dropped
        end
    end

    always_ff @(posedge SYS_clk)
    begin
        m_reg_write <= mem_in.reg_write;
        m_mem_read  <= mem_in.mem_read;
        m_mem_write <= mem_in.mem_write;
        m_dest      <= mem_in.dest;
        m_alu       <= mem_in.alu_result;
        m_store     <= mem_in.store_data;
        wb_out.dest <= m_dest;
        wb_out.data <= m_mem_read ? load_data : m_alu;
    end

    assign word_addr = pipe_pkg::dmem_addr_t'(m_alu >> pipe_pkg::WORD_LSB);
    assign load_data = dmem[word_addr];   // combinational read

    always_ff @(posedge SYS_clk)
    begin
        if (m_valid && m_mem_write)
            dmem[word_addr] <= m_store;
    end

    assign mem_in.pend_write = m_valid && m_reg_write;
    assign mem_in.pend_dest  = m_dest;

endmodule

// File: src/mips_core.sv
//****************************
// MIPS subset core, top level
//****************************
module mips_core (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               instr_valid,
    input  isa_pkg::word_t     instr,
    output logic               instr_credit,
    output logic               wb_valid,
    output isa_pkg::reg_addr_t wb_reg,
    output isa_pkg::word_t     wb_data
);
    issue_if issue_bus ();
    ex_if    ex_bus ();
    mem_if   mem_bus ();
    wb_if    wb_bus ();

    fetch_queue u_fetch_queue (
        .SYS_clk     (SYS_clk),
        .SYS_reset   (SYS_reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .credit      (instr_credit),
        .issue       (issue_bus)
    );

    decode_stage u_decode (
        .SYS_clk  (SYS_clk),
        .SYS_reset(SYS_reset),
        .issue    (issue_bus),
        .ex_out   (ex_bus),
        .mem_peek (mem_bus),
        .wb       (wb_bus)
    );

    execute_stage u_execute (
        .SYS_clk  (SYS_clk),
        .SYS_reset(SYS_reset),
        .ex_in    (ex_bus),
        .mem_out  (mem_bus)
    );

    memory_stage u_memory (
        .SYS_clk  (SYS_clk),
        .SYS_reset(SYS_reset),
        .mem_in   (mem_bus),
        .wb_out   (wb_bus)
    );

    // writeback trace leaves the core here
    assign wb_valid = wb_bus.valid;
    assign wb_reg   = wb_bus.dest;
    assign wb_data  = wb_bus.data;

endmodule

// File: test/mips_checker.sv
//****************************
// writeback checker with its own register and memory model
//****************************
module mips_checker (
    input  logic               SYS_clk,
    input  logic               SYS_reset,
    input  logic               instr_valid,
    input  isa_pkg::word_t     instr,
    input  logic               instr_credit,
    input  logic               wb_valid,
    input  isa_pkg::reg_addr_t wb_reg,
    input  isa_pkg::word_t     wb_data,
    input  isa_pkg::reg_addr_t exp_reg,    // table entry sent with instr, r0 means none
    input  isa_pkg::word_t     exp_data,
    input  logic               run_done,
    output int                 value_errors,
    output int                 other_errors,
    output int                 wb_seen,
    output int                 pending
);
    timeunit 1ns;
    timeprecision 1ps;

    isa_pkg::word_t     regs [isa_pkg::REG_COUNT];
    isa_pkg::word_t     dmem [pipe_pkg::DMEM_DEPTH];
    isa_pkg::reg_addr_t exp_dest_q [$];
    isa_pkg::word_t     exp_val_q [$];
    int                 sent;
    int                 credits_back;
    logic               closed;

    // architectural effect of one instruction, dest is r0 when nothing is written
    task automatic predict(input isa_pkg::word_t w, output isa_pkg::reg_addr_t dest,
                           output isa_pkg::word_t val);
        isa_pkg::word_t a;
        isa_pkg::word_t b;
        isa_pkg::word_t imm;
        isa_pkg::word_t addr;
        a    = regs[w[25:21]];
        b    = regs[w[20:16]];
        imm  = {{16{w[15]}}, w[15:0]};
        addr = a + imm;
        dest = '0;
        val  = '0;
        case (w[31:26])
            isa_pkg::OP_RTYPE:
            begin
                dest = w[15:11];
                case (w[5:0])
                    isa_pkg::FN_ADD: val = a + b;
                    isa_pkg::FN_SUB: val = a - b;
                    isa_pkg::FN_AND: val = a & b;
                    isa_pkg::FN_OR:  val = a | b;
                    isa_pkg::FN_SLT: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         dest = '0;   // unknown funct
                endcase
            end
            isa_pkg::OP_ADDI:
            begin
                dest = w[20:16];
                val  = a + imm;
            end
            isa_pkg::OP_LW:
            begin
                dest = w[20:16];
                val  = dmem[addr[7:2]];
            end
            isa_pkg::OP_SW: dmem[addr[7:2]] = b;
            default: ;
        endcase
        if (dest != '0)
            regs[dest] = val;
    endtask

    always @(posedge SYS_clk)
    begin
        isa_pkg::reg_addr_t dest;
        isa_pkg::word_t     val;
        if (SYS_reset)
        begin
            foreach (regs[i])
                regs[i] = '0;
            foreach (dmem[i])
                dmem[i] = '0;
            exp_dest_q.delete();
            exp_val_q.delete();
            {value_errors, other_errors, wb_seen, sent, credits_back} = '0;
            closed = 1'b0;
        end
        else
        begin
            if (instr_credit)
                credits_back++;
            if (instr_valid)
            begin
                sent++;
                predict(instr, dest, val);
                if (dest != exp_reg || (dest != '0 && val != exp_data))
                begin
                    other_errors++;
                    $display("program row %0d: table gives r%0d = %h but the model gives r%0d = %h",
                             sent, exp_reg, exp_data, dest, val);
                end
                if (dest != '0)
                begin
                    exp_dest_q.push_back(dest);
                    exp_val_q.push_back(val);
                end
            end
            if (wb_valid)
            begin
                wb_seen++;
                if (exp_dest_q.size() == 0)
                begin
                    other_errors++;
                    $display("writeback to r%0d at %0t ns with nothing expected", wb_reg, $time);
                end
                else
                begin
                    dest = exp_dest_q.pop_front();
                    val  = exp_val_q.pop_front();
                    if (wb_reg !== dest)
                    begin
                        value_errors++;
                        $display("error at %0t ns: wb_reg expected %0d, got %0d",
                                 $time, dest, wb_reg);
                    end
                    if (wb_data !== val)
                    begin
                        value_errors++;
                        $display("error at %0t ns: wb_data expected %h, got %h",
                                 $time, val, wb_data);
                    end
                end
            end
            if (run_done && !closed)   // end of run bookkeeping, once
            begin
                closed = 1'b1;
                if (credits_back != sent)
                begin
                    other_errors++;
                    $display("%0d credits came back for %0d instructions sent",
                             credits_back, sent);
                end
                if (exp_dest_q.size() != 0)
                begin
                    other_errors++;
                    $display("%0d expected writebacks never arrived", exp_dest_q.size());
                end
            end
        end
        pending = exp_dest_q.size();
    end

endmodule

// File: test/mips_properties.sv
//****************************
// assertions on the credit protocol
// and on the writeback port after reset
//****************************
module mips_properties (
    input logic SYS_clk,
    input logic SYS_reset,
    input logic instr_valid,
    input logic instr_credit,
    input logic wb_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    int credits;   // sender credits as seen from the core side

    always_ff @(posedge SYS_clk)
    begin
        if (SYS_reset)
            credits <= pipe_pkg::FETCH_DEPTH;
        else
            credits <= credits + int'(instr_credit) - int'(instr_valid);
    end

    // a credit coming back this cycle may already be spent
    push_needs_credit: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        instr_valid |-> (credits + int'(instr_credit)) > 0)
        else $error("instruction pushed with no credit left");

    // a credit only comes back for an instruction still outstanding
    credit_needs_take: assert property (@(posedge SYS_clk) disable iff (SYS_reset)
        instr_credit |-> credits < pipe_pkg::FETCH_DEPTH)
        else $error("credit returned with no instruction taken from the queue");

    wb_quiet_after_reset: assert property (@(posedge SYS_clk)
        $fell(SYS_reset) |-> !wb_valid)
        else $error("writeback valid right after reset");

endmodule

bind mips_core mips_properties u_properties (
    .SYS_clk      (SYS_clk),
    .SYS_reset    (SYS_reset),
    .instr_valid  (instr_valid),
    .instr_credit (instr_credit),
    .wb_valid     (wb_valid)
);

// File: test/tb_mips.sv
//****************************
// testbench for the MIPS subset core
// credit-counting sender over a program table
//****************************
module tb_mips;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 200;

    logic               SYS_clk;
    logic               SYS_reset;
    logic               instr_valid;
    isa_pkg::word_t     instr;
    logic               instr_credit;
    logic               wb_valid;
    isa_pkg::reg_addr_t wb_reg;
    isa_pkg::word_t     wb_data;
    isa_pkg::reg_addr_t exp_reg;
    isa_pkg::word_t     exp_data;
    logic               run_done;
    int                 value_errors;
    int                 other_errors;
    int                 wb_seen;
    int                 pending;

    isa_pkg::word_t     prog_instr [$];
    isa_pkg::reg_addr_t prog_dest [$];   // r0 when no writeback is due
    isa_pkg::word_t     prog_value [$];
    int                 credits;
    int                 sent;
    logic               timed_out;

    always #50 SYS_clk = ~SYS_clk;

    mips_core u_dut (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data)
    );

    mips_checker u_checker (
        .SYS_clk      (SYS_clk),
        .SYS_reset    (SYS_reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .instr_credit (instr_credit),
        .wb_valid     (wb_valid),
        .wb_reg       (wb_reg),
        .wb_data      (wb_data),
        .exp_reg      (exp_reg),
        .exp_data     (exp_data),
        .run_done     (run_done),
        .value_errors (value_errors),
        .other_errors (other_errors),
        .wb_seen      (wb_seen),
        .pending      (pending)
    );

    function automatic isa_pkg::word_t encode_rtype(int rs, int rt, int rd, isa_pkg::funct_t fn);
        return {isa_pkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
    endfunction

    function automatic isa_pkg::word_t encode_itype(isa_pkg::opcode_t op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    task automatic add_row(isa_pkg::word_t word, int dest, int value);
        prog_instr.push_back(word);
        prog_dest.push_back(dest[4:0]);
        prog_value.push_back(value);
    endtask

    task automatic build_program();
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 1, 5), 1, 5);
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 2, -3), 2, -3);
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 3, 12), 3, 12);
        add_row(encode_rtype(1, 3, 4, isa_pkg::FN_ADD), 4, 17);
        add_row(encode_rtype(3, 1, 5, isa_pkg::FN_SUB), 5, 7);
        add_row(encode_rtype(3, 1, 6, isa_pkg::FN_AND), 6, 4);
        add_row(encode_rtype(3, 1, 7, isa_pkg::FN_OR), 7, 13);
        add_row(encode_rtype(2, 1, 8, isa_pkg::FN_SLT), 8, 1);   // -3 < 5
        add_row(encode_rtype(1, 2, 9, isa_pkg::FN_SLT), 9, 0);
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 10, 100), 10, 100);
        add_row(encode_rtype(10, 10, 11, isa_pkg::FN_ADD), 11, 200);   // rs and rt one slot back
        add_row(encode_rtype(11, 1, 12, isa_pkg::FN_SUB), 12, 195);
        add_row(encode_rtype(1, 12, 13, isa_pkg::FN_ADD), 13, 200);
        add_row(encode_itype(isa_pkg::OP_ADDI, 13, 14, 1), 14, 201);
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 16, 7), 16, 7);
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 17, 9), 17, 9);
        add_row(encode_rtype(16, 17, 18, isa_pkg::FN_ADD), 18, 16);   // two slots and one slot
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 19, 64), 19, 64);
        add_row(encode_itype(isa_pkg::OP_SW, 19, 4, 8), 0, 0);   // word 18
        add_row(encode_itype(isa_pkg::OP_SW, 19, 18, 0), 0, 0);   // word 16
        add_row(encode_itype(isa_pkg::OP_LW, 19, 20, 8), 20, 17);
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 21, 72), 21, 72);
        add_row(encode_itype(isa_pkg::OP_LW, 21, 22, 0), 22, 17);   // right after its address
        add_row(encode_itype(isa_pkg::OP_LW, 19, 23, 0), 23, 16);
        add_row(encode_itype(isa_pkg::OP_ADDI, 0, 0, 55), 0, 0);   // r0 write, no writeback
        add_row(encode_rtype(0, 1, 24, isa_pkg::FN_ADD), 24, 5);
        add_row(32'hfc00_0000, 0, 0);   // unknown opcode
        add_row(encode_rtype(1, 1, 25, 6'h3f), 0, 0);   // unknown funct
        add_row(encode_rtype(24, 24, 25, isa_pkg::FN_ADD), 25, 10);
        add_row(encode_rtype(2, 1, 26, isa_pkg::FN_SUB), 26, -8);
        add_row(encode_rtype(26, 2, 27, isa_pkg::FN_SLT), 27, 1);   // -8 < -3
    endtask

    // step to the next falling edge and pick up a returned credit
    task automatic next_cycle();
        @(negedge SYS_clk);
        if (instr_credit)
            credits++;
    endtask

    task automatic wait_for_credit();
        int waited;
        waited = 0;
        while (credits == 0 && !timed_out)
        begin
            instr_valid = 1'b0;
            next_cycle();
            waited++;
            if (waited > TIMEOUT_CYCLES)
            begin
                timed_out = 1'b1;
                $display("timeout: no credit came back from the core");
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (!timed_out && (pending != 0 || credits != pipe_pkg::FETCH_DEPTH))
        begin
            next_cycle();
            waited++;
            if (waited > TIMEOUT_CYCLES)
            begin
                timed_out = 1'b1;
                $display("timeout: %0d writebacks missing, %0d credits held", pending, credits);
            end
        end
    endtask

    initial
    begin
        int idle;
        void'($urandom(32'hf5c9_6ea7));
        SYS_clk     = 1'b0;
        SYS_reset   = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        exp_reg     = '0;
        exp_data    = '0;
        run_done    = 1'b0;
        credits     = 0;
        sent        = 0;
        timed_out   = 1'b0;
        build_program();
        repeat (8) @(negedge SYS_clk);
        SYS_reset = 1'b0;
        credits   = pipe_pkg::FETCH_DEPTH;
        for (int i = 0; i < prog_instr.size() && !timed_out; i++)
        begin
            idle = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
            repeat (idle)
            begin
                instr_valid = 1'b0;
                next_cycle();
            end
            wait_for_credit();
            if (!timed_out)
            begin
                instr_valid = 1'b1;
                instr       = prog_instr[i];
                exp_reg     = prog_dest[i];
                exp_data    = prog_value[i];
                credits--;
                sent++;
                next_cycle();
            end
        end
        instr_valid = 1'b0;
        drain();
        repeat (4) next_cycle();   // quiet time, catches extra writebacks
        run_done = 1'b1;
        next_cycle();
        next_cycle();
        $display("summary: %0d sent, %0d writebacks, %0d value errors, %0d other errors, %0d timeouts",
                 sent, wb_seen, value_errors, other_errors, int'(timed_out));
        if (!timed_out && value_errors == 0 && other_errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

// File: verilog.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/pipe_if.sv
src/fetch_queue.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/mips_core.sv
test/mips_checker.sv
test/mips_properties.sv
test/tb_mips.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and search the log for the result
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal -f verilog.f \
        --top-module tb_mips -o sim_tb_mips \
    && ./obj_dir/sim_tb_mips > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^all tests passed$" sim.log \
    && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }
